//--- sim.f
src/player_pkg.sv
src/player_regs.sv
src/song_rom.sv
src/song_sequencer.sv
src/tone_divider.sv
src/music_player.sv
dv/music_player_props.sv
dv/music_player_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the melody player testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module music_player_tb \
   -f sim.f -Mdir obj_dir -o music_player_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/music_player_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -qx "Simulation passed" sim.log; then
   exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- dv/music_player_tb.sv
// music_player_tb: drives the melody player over APB and checks notes, tone period and bus errors
`timescale 1ns/1ns
module music_player_tb;

   localparam int beat_div = 40000;
   localparam int tone_max = 16383;
   localparam int preset_tab [12] = '{16383, 7281, 8730, 9565, 10310, 10647,
                                      11272, 11831, 12556, 12974, 13347, 13516};
   localparam logic [11:0] digit_tab [12] = '{12'h000, 12'h003, 12'h005, 12'h006, 12'h007,
                                              12'h010, 12'h020, 12'h030, 12'h050, 12'h060,
                                              12'h070, 12'h100};  // high, med, low nibbles

   logic                     clk_4hz;
   logic                     reset;
   player_pkg::apb_req_t     apb;
   player_pkg::apb_rsp_t     apb_resp;
   logic                     speaker;
   player_pkg::note_digits_t digits;
   player_pkg::note_digits_t exp_digits;
   logic                     watch_digits;
   integer                   seed;
   int                       cycle_count = 0;
   int                       errors = 0;
   int                       tests = 0;
   int                       test_errors = 0;

   music_player #(
      .beat_div (beat_div)
   ) dut0 (
      .clk_4hz  (clk_4hz),
      .reset    (reset),
      .apb      (apb),
      .apb_resp (apb_resp),
      .speaker  (speaker),
      .digits   (digits)
   );

   always #10 clk_4hz = ~clk_4hz;

   always @(posedge clk_4hz) cycle_count <= cycle_count + 1;

   function automatic int ref_preset(player_pkg::note_t n);
      return preset_tab[int'(n)];
   endfunction

   function automatic player_pkg::note_digits_t ref_digits(player_pkg::note_t n);
      return player_pkg::note_digits_t'(digit_tab[int'(n)]);
   endfunction

   function automatic int ref_half_period(player_pkg::note_t n);
      return tone_max - ref_preset(n) + 1;
   endfunction

   // note heard at a beat inside the first two events of a song
   function automatic player_pkg::note_t ref_song_start(int song, int beat);
      if (song == 0)
         return (beat < 4) ? player_pkg::lo3 : player_pkg::lo5;
      return (beat < 2) ? player_pkg::mid3 : player_pkg::mid2;
   endfunction

   always @(negedge clk_4hz)
   begin
      if (watch_digits && digits !== exp_digits)
      begin
         $display("Error at %0t: digits %h, expected %h", $time, digits, exp_digits);
         errors = errors + 1;
      end
   end

   task automatic fail_check(input string msg);
      $display("Error at %0t: %s", $time, msg);
      errors = errors + 1;
   endtask

   task automatic abort_on_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Simulation failed");
      $finish;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk_4hz);
      #1;                                                    // back to drive point
   endtask

   task automatic apb_access(input logic write, input logic [3:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      int n;
      n = 0;
      apb.psel   = 1'b1;                                     // setup phase
      apb.pwrite = write;
      apb.paddr  = addr;
      apb.pwdata = wdata;
      @(posedge clk_4hz);
      #1;
      apb.penable = 1'b1;
      #1;
      while (!apb_resp.pready && n < 16)
      begin
         @(posedge clk_4hz);
         #2;
         n++;
      end
      if (!apb_resp.pready)
         abort_on_timeout("pready");
      else
      begin
         rdata = apb_resp.prdata;
         err   = apb_resp.pslverr;
         @(posedge clk_4hz);                                 // transfer completes here
         #1;
         apb = '0;
      end
   endtask

   task automatic wait_status(input int exp, output int at);
      logic [31:0] data;
      logic        err;
      int          n;
      n    = 0;
      data = '1;
      while (data != exp && n <= 3 * beat_div)
      begin
         apb_access(1'b0, player_pkg::status_addr, '0, data, err);
         n += 2;
      end
      if (data != exp)
         abort_on_timeout("the song position");
      else
         at = cycle_count;
   endtask

   task automatic wait_speaker_edge(output int at);
      logic prev;
      int   n;
      prev = speaker;
      n    = 0;
      while (speaker == prev && n <= 2 * tone_max)
      begin
         @(posedge clk_4hz);
         #1;
         n++;
      end
      if (speaker == prev)
         abort_on_timeout("a speaker edge");
      else
         at = cycle_count;
   endtask

   task automatic check_mid_beat(input player_pkg::note_t n, input int exp_beat);
      logic [31:0] data;
      logic        err;
      wait_cycles(beat_div / 2 + $random(seed) % (beat_div / 4));
      exp_digits   = ref_digits(n);
      watch_digits = 1'b1;                                   // compared on the next negedges
      apb_access(1'b0, player_pkg::status_addr, '0, data, err);
      watch_digits = 1'b0;
      if (data != exp_beat)
         fail_check($sformatf("status %0d, expected %0d", data, exp_beat));
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == test_errors)
         $display("test %0d %s: ok", tests, name);
      else
         $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
      test_errors = errors;
   endtask

   initial
   begin
      logic [31:0] data;
      logic        err;
      int          t1;
      int          t2;
      clk_4hz      = 1'b0;
      reset        = 1'b1;
      apb          = '0;
      seed         = 32'h9758bc06;
      watch_digits = 1'b0;
      exp_digits   = '0;
      repeat (2) @(posedge clk_4hz);
      #1;
      reset = 1'b0;

      if (speaker !== 1'b0 || digits !== '0)
         fail_check("speaker or digits not clear after reset");
      apb_access(1'b0, player_pkg::status_addr, '0, data, err);
      if (data !== 32'h0 || err !== 1'b0)
         fail_check($sformatf("status %h after reset, expected 0", data));
      apb_access(1'b1, player_pkg::ctrl_addr, 32'h4, data, err);    // play, song 0
      apb_access(1'b0, player_pkg::ctrl_addr, '0, data, err);
      if (data !== 32'h4)
         fail_check($sformatf("ctrl read %h, expected 4", data));
      end_test("reset and registers");

      check_mid_beat(ref_song_start(0, 0), 0);
      wait_status(1, t1);
      wait_status(2, t2);
      if (t2 - t1 != beat_div)
         fail_check($sformatf("beat lasted %0d cycles, expected %0d", t2 - t1, beat_div));
      wait_status(4, t1);
      check_mid_beat(ref_song_start(0, 4), 4);
      end_test("song 0 notes");

      apb_access(1'b1, player_pkg::ctrl_addr, 32'h6, data, err);    // play and pause
      wait_speaker_edge(t1);
      wait_speaker_edge(t2);
      if (t2 - t1 != ref_half_period(ref_song_start(0, 4)))
         fail_check($sformatf("speaker half period %0d cycles, expected %0d", t2 - t1,
                              ref_half_period(ref_song_start(0, 4))));
      wait_cycles(beat_div);
      check_mid_beat(ref_song_start(0, 4), 4);
      end_test("tone period");

      apb_access(1'b1, player_pkg::ctrl_addr, 32'h5, data, err);    // play, song 1
      check_mid_beat(ref_song_start(1, 0), 0);
      wait_status(2, t1);
      check_mid_beat(ref_song_start(1, 2), 2);
      end_test("song switch");

      apb_access(1'b0, 4'h8, '0, data, err);
      if (err !== 1'b1)
         fail_check("no pslverr on a read of an unmapped address");
      apb_access(1'b1, player_pkg::status_addr, 32'h0, data, err);
      if (err !== 1'b1)
         fail_check("no pslverr on a write to status");
      apb_access(1'b0, player_pkg::ctrl_addr, '0, data, err);
      if (data !== 32'h5 || err !== 1'b0)
         fail_check($sformatf("ctrl read %h after bus errors, expected 5", data));
      end_test("bus errors");

      apb_access(1'b1, player_pkg::ctrl_addr, 32'h0, data, err);
      wait_cycles(3);                                        // rest reaches the divider
      if (digits !== '0 || speaker !== 1'b0)
         fail_check("digits or speaker still active after stop");
      apb_access(1'b0, player_pkg::status_addr, '0, data, err);
      if (data !== 32'h0)
         fail_check($sformatf("status %0d after stop, expected 0", data));
      end_test("stop");

      $display("%0d tests run, %0d checks failed", tests, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- dv/music_player_props.sv
// music_player_props: assertions on song position range, silence during rests and APB response
`timescale 1ns/1ns
module music_player_props (
   input logic                     clk_4hz,
   input logic                     reset,
   input player_pkg::beat_t        beat,
   input player_pkg::note_t        note,
   input logic                     speaker,
   input player_pkg::apb_req_t     apb,
   input player_pkg::apb_rsp_t     apb_resp,
   input player_pkg::player_ctrl_t ctrl
);

   beat_in_range: assert property (@(posedge clk_4hz) disable iff (reset)
      beat < player_pkg::song_len)
      else $error("song position outside 0 to 149");

   rest_is_silent: assert property (@(posedge clk_4hz) disable iff (reset)
      (note == player_pkg::rest) |=> !speaker)
      else $error("speaker high during a rest");

   // a rejected transfer leaves the control register alone
   err_keeps_ctrl: assert property (@(posedge clk_4hz) disable iff (reset)
      (apb.psel && apb.penable && apb_resp.pslverr) |=> $stable(ctrl))
      else $error("ctrl changed by a failed access");

   idle_no_error: assert property (@(posedge clk_4hz) disable iff (reset)
      !(apb.psel && apb.penable) |-> !apb_resp.pslverr)
      else $error("pslverr outside an access phase");

endmodule

bind music_player music_player_props props0 (
   .clk_4hz  (clk_4hz),
   .reset    (reset),
   .beat     (beat),
   .note     (note),
   .speaker  (speaker),
   .apb      (apb),
   .apb_resp (apb_resp),
   .ctrl     (ctrl)
);

//--- src/music_player.sv
// music_player: APB-controlled two-song melody player with speaker and note display
`timescale 1ns/1ns
module music_player #(
   parameter int beat_div = 40000
) (
   input  logic                     clk_4hz,
   input  logic                     reset,
   input  player_pkg::apb_req_t     apb,
   output player_pkg::apb_rsp_t     apb_resp,
   output logic                     speaker,
   output player_pkg::note_digits_t digits
);

   player_pkg::player_ctrl_t ctrl;
   player_pkg::beat_t        beat;
   player_pkg::event_idx_t   event_idx;
   player_pkg::note_t        rom_note;
   player_pkg::dur_t         rom_dur;
   logic                     rom_last;
   player_pkg::note_t        note;

   player_regs regs0 (
      .clk_4hz  (clk_4hz),
      .reset    (reset),
      .apb      (apb),
      .apb_resp (apb_resp),
      .beat     (beat),
      .ctrl     (ctrl)
   );

   song_sequencer #(
      .beat_div (beat_div)
   ) seq0 (
      .clk_4hz   (clk_4hz),
      .reset     (reset),
      .ctrl      (ctrl),
      .rom_note  (rom_note),
      .rom_dur   (rom_dur),
      .rom_last  (rom_last),
      .event_idx (event_idx),
      .beat      (beat),
      .note      (note),
      .digits    (digits)
   );

   song_rom rom0 (
      .song      (ctrl.song),                                // table follows the selected song
      .event_idx (event_idx),
      .note      (rom_note),
      .dur       (rom_dur),
      .last      (rom_last)
   );

   tone_divider tone0 (
      .clk_4hz (clk_4hz),
      .reset   (reset),
      .note    (note),
      .speaker (speaker)
   );

endmodule

//--- src/tone_divider.sv
// tone_divider: preset counter that toggles the speaker at the pitch of the current note
`timescale 1ns/1ns
module tone_divider (
   input  logic              clk_4hz,
   input  logic              reset,
   input  player_pkg::note_t note,
   output logic              speaker
);

   player_pkg::tone_count_t preset;
   player_pkg::tone_count_t count;
   player_pkg::note_t       note_q;
   logic                    terminal;
   logic                    changed;

   assign preset   = player_pkg::note_preset(note);
   assign terminal = (count == player_pkg::tone_max);
   assign changed  = (note != note_q);

   always_ff @(posedge clk_4hz)
   begin
      if (reset)
      begin
         count   <= '0;
         note_q  <= player_pkg::rest;
         speaker <= 1'b0;
      end
      else
      begin
         note_q <= note;
         if (changed || terminal)
         begin
            count <= preset;                                 // restart the half period
         end
         else
         begin
            count <= count + 1'b1;
         end

         if (note == player_pkg::rest)
         begin
            speaker <= 1'b0;                                 // silent during a rest
         end
         else if (terminal && !changed)
         begin
            speaker <= ~speaker;
         end
      end
   end

endmodule

//--- src/song_sequencer.sv
// song_sequencer: beat prescaler, note-event walker and song position counter
`timescale 1ns/1ns
module song_sequencer #(
   parameter int beat_div = 40000
) (
   input  logic                     clk_4hz,
   input  logic                     reset,
   input  player_pkg::player_ctrl_t ctrl,
   input  player_pkg::note_t        rom_note,
   input  player_pkg::dur_t         rom_dur,
   input  logic                     rom_last,
   output player_pkg::event_idx_t   event_idx,
   output player_pkg::beat_t        beat,
   output player_pkg::note_t        note,
   output player_pkg::note_digits_t digits
);

   localparam int presc_w = (beat_div > 1) ? $clog2(beat_div) : 1;
   localparam player_pkg::beat_t last_beat = player_pkg::beat_t'(player_pkg::song_len - 1);

   logic [presc_w-1:0]    presc;
   player_pkg::dur_t      dur_left;                 // beats left after the current one
   player_pkg::song_sel_t song_q;
   logic                  active;
   logic                  restart;
   logic                  tick;
   logic                  load;

   assign restart = !ctrl.play || (ctrl.song != song_q);   // stopped or song switched
   assign tick    = active && !ctrl.pause && (presc == presc_w'(beat_div - 1));
   assign load    = !ctrl.pause && (!active || (tick && dur_left == '0));

   always_ff @(posedge clk_4hz)
   begin
      if (reset)
      begin
         song_q <= '0;
      end
      else
      begin
         song_q <= ctrl.song;                                // last seen song
      end
   end

   always_ff @(posedge clk_4hz)
   begin
      if (reset || restart)
      begin
         presc     <= '0;
         beat      <= '0;
         event_idx <= '0;
         dur_left  <= '0;
         active    <= 1'b0;
         note      <= player_pkg::rest;
         digits    <= '0;
      end
      else
      begin
         if (active && !ctrl.pause)
         begin
            presc <= tick ? '0 : presc + 1'b1;
         end
         if (tick)
         begin
            beat <= (beat == last_beat) ? '0 : beat + 1'b1;
         end
         if (load)
         begin
            // start of play or end of event, take the next one
            active    <= 1'b1;
            note      <= rom_note;
            digits    <= player_pkg::note_to_digits(rom_note);
            dur_left  <= rom_dur - 1'b1;
            event_idx <= rom_last ? '0 : event_idx + 1'b1;
         end
         else if (tick)
         begin
            dur_left <= dur_left - 1'b1;
         end
      end
   end

endmodule

//--- src/song_rom.sv
// song_rom: both melodies stored as run-length note events, looked up combinationally
`timescale 1ns/1ns
module song_rom (
   input  player_pkg::song_sel_t  song,
   input  player_pkg::event_idx_t event_idx,
   output player_pkg::note_t      note,
   output player_pkg::dur_t       dur,
   output logic                   last
);

   typedef struct packed {
      player_pkg::note_t note;
      player_pkg::dur_t  dur;
   } event_t;

   localparam player_pkg::event_idx_t song0_last = 7'd76;
   localparam player_pkg::event_idx_t song1_last = 7'd34;

   event_t ev;

   always_comb
   begin
      if (song == 1'b0)
      begin
         case (event_idx)
            7'd0:    ev = '{player_pkg::lo3,  5'd4};
            7'd1:    ev = '{player_pkg::lo5,  5'd3};
            7'd2:    ev = '{player_pkg::lo6,  5'd1};
            7'd3:    ev = '{player_pkg::mid1, 5'd3};
            7'd4:    ev = '{player_pkg::mid2, 5'd1};
            7'd5:    ev = '{player_pkg::lo6,  5'd1};
            7'd6:    ev = '{player_pkg::mid1, 5'd1};
            7'd7:    ev = '{player_pkg::lo5,  5'd2};
            7'd8:    ev = '{player_pkg::mid5, 5'd3};
            7'd9:    ev = '{player_pkg::hi1,  5'd1};   // only high-octave note
            7'd10:   ev = '{player_pkg::mid6, 5'd1};
            7'd11:   ev = '{player_pkg::mid5, 5'd1};
            7'd12:   ev = '{player_pkg::mid3, 5'd1};
            7'd13:   ev = '{player_pkg::mid5, 5'd1};
            7'd14:   ev = '{player_pkg::mid2, 5'd11};
            7'd15:   ev = '{player_pkg::mid3, 5'd1};
            7'd16:   ev = '{player_pkg::lo7,  5'd2};
            7'd17:   ev = '{player_pkg::lo6,  5'd2};
            7'd18:   ev = '{player_pkg::lo5,  5'd3};
            7'd19:   ev = '{player_pkg::lo6,  5'd1};
            7'd20:   ev = '{player_pkg::mid1, 5'd2};
            7'd21:   ev = '{player_pkg::mid2, 5'd2};
            7'd22:   ev = '{player_pkg::lo3,  5'd2};
            7'd23:   ev = '{player_pkg::mid1, 5'd2};
            7'd24:   ev = '{player_pkg::lo6,  5'd1};
            7'd25:   ev = '{player_pkg::lo5,  5'd1};
            7'd26:   ev = '{player_pkg::lo6,  5'd1};
            7'd27:   ev = '{player_pkg::mid1, 5'd1};
            7'd28:   ev = '{player_pkg::lo5,  5'd8};
            7'd29:   ev = '{player_pkg::mid3, 5'd3};
            7'd30:   ev = '{player_pkg::mid5, 5'd1};
            7'd31:   ev = '{player_pkg::lo7,  5'd2};
            7'd32:   ev = '{player_pkg::mid2, 5'd2};
            7'd33:   ev = '{player_pkg::lo6,  5'd1};
            7'd34:   ev = '{player_pkg::mid1, 5'd1};
            7'd35:   ev = '{player_pkg::lo5,  5'd4};
            7'd36:   ev = '{player_pkg::rest, 5'd2};   // beats 78 and 79
            7'd37:   ev = '{player_pkg::lo3,  5'd1};
            7'd38:   ev = '{player_pkg::lo5,  5'd2};
            7'd39:   ev = '{player_pkg::lo3,  5'd1};
            7'd40:   ev = '{player_pkg::lo5,  5'd1};
            7'd41:   ev = '{player_pkg::lo6,  5'd1};
            7'd42:   ev = '{player_pkg::lo7,  5'd1};
            7'd43:   ev = '{player_pkg::mid2, 5'd1};
            7'd44:   ev = '{player_pkg::lo6,  5'd6};
            7'd45:   ev = '{player_pkg::lo5,  5'd1};
            7'd46:   ev = '{player_pkg::lo6,  5'd1};
            7'd47:   ev = '{player_pkg::mid1, 5'd3};
            7'd48:   ev = '{player_pkg::mid2, 5'd1};
            7'd49:   ev = '{player_pkg::mid5, 5'd2};
            7'd50:   ev = '{player_pkg::mid3, 5'd2};
            7'd51:   ev = '{player_pkg::mid2, 5'd2};
            7'd52:   ev = '{player_pkg::mid3, 5'd1};
            7'd53:   ev = '{player_pkg::mid2, 5'd1};
            7'd54:   ev = '{player_pkg::mid1, 5'd2};
            7'd55:   ev = '{player_pkg::lo6,  5'd1};
            7'd56:   ev = '{player_pkg::lo5,  5'd1};
            7'd57:   ev = '{player_pkg::lo3,  5'd4};
            7'd58:   ev = '{player_pkg::mid1, 5'd4};
            7'd59:   ev = '{player_pkg::lo6,  5'd1};
            7'd60:   ev = '{player_pkg::mid1, 5'd1};
            7'd61:   ev = '{player_pkg::lo6,  5'd1};
            7'd62:   ev = '{player_pkg::lo5,  5'd1};
            7'd63:   ev = '{player_pkg::lo3,  5'd1};
            7'd64:   ev = '{player_pkg::lo5,  5'd1};
            7'd65:   ev = '{player_pkg::lo6,  5'd1};
            7'd66:   ev = '{player_pkg::mid1, 5'd1};
            7'd67:   ev = '{player_pkg::lo5,  5'd6};
            7'd68:   ev = '{player_pkg::mid3, 5'd1};
            7'd69:   ev = '{player_pkg::mid5, 5'd1};
            7'd70:   ev = '{player_pkg::mid2, 5'd1};
            7'd71:   ev = '{player_pkg::mid3, 5'd1};
            7'd72:   ev = '{player_pkg::mid2, 5'd1};
            7'd73:   ev = '{player_pkg::mid1, 5'd1};
            7'd74:   ev = '{player_pkg::lo7,  5'd2};
            7'd75:   ev = '{player_pkg::lo6,  5'd2};
            7'd76:   ev = '{player_pkg::lo5,  5'd6};   // ends on beat 149
            default: ev = '{player_pkg::rest, 5'd1};
         endcase
      end
      else
      begin
         case (event_idx)
            7'd0:    ev = '{player_pkg::mid3, 5'd2};
            7'd1:    ev = '{player_pkg::mid2, 5'd2};
            7'd2:    ev = '{player_pkg::mid3, 5'd10};
            7'd3:    ev = '{player_pkg::mid2, 5'd2};
            7'd4:    ev = '{player_pkg::mid3, 5'd2};
            7'd5:    ev = '{player_pkg::mid2, 5'd2};
            7'd6:    ev = '{player_pkg::mid1, 5'd12};
            7'd7:    ev = '{player_pkg::lo6,  5'd2};
            7'd8:    ev = '{player_pkg::mid1, 5'd2};
            7'd9:    ev = '{player_pkg::mid2, 5'd6};
            7'd10:   ev = '{player_pkg::mid3, 5'd2};
            7'd11:   ev = '{player_pkg::mid2, 5'd2};
            7'd12:   ev = '{player_pkg::mid1, 5'd2};
            7'd13:   ev = '{player_pkg::lo6,  5'd2};
            7'd14:   ev = '{player_pkg::mid1, 5'd2};
            7'd15:   ev = '{player_pkg::lo5,  5'd16};
            7'd16:   ev = '{player_pkg::mid3, 5'd2};   // second verse
            7'd17:   ev = '{player_pkg::mid2, 5'd2};
            7'd18:   ev = '{player_pkg::mid3, 5'd10};
            7'd19:   ev = '{player_pkg::mid2, 5'd2};
            7'd20:   ev = '{player_pkg::mid3, 5'd2};
            7'd21:   ev = '{player_pkg::mid2, 5'd2};
            7'd22:   ev = '{player_pkg::mid1, 5'd17};  // longest event
            7'd23:   ev = '{player_pkg::lo6,  5'd2};
            7'd24:   ev = '{player_pkg::mid1, 5'd2};
            7'd25:   ev = '{player_pkg::mid2, 5'd6};
            7'd26:   ev = '{player_pkg::mid3, 5'd2};
            7'd27:   ev = '{player_pkg::mid2, 5'd2};
            7'd28:   ev = '{player_pkg::mid1, 5'd2};
            7'd29:   ev = '{player_pkg::lo6,  5'd2};
            7'd30:   ev = '{player_pkg::mid1, 5'd2};
            7'd31:   ev = '{player_pkg::mid2, 5'd16};
            7'd32:   ev = '{player_pkg::mid3, 5'd2};
            7'd33:   ev = '{player_pkg::mid2, 5'd2};
            7'd34:   ev = '{player_pkg::mid3, 5'd5};
            default: ev = '{player_pkg::rest, 5'd1};
         endcase
      end
   end

   assign note = ev.note;
   assign dur  = ev.dur;
   assign last = (song == 1'b0) ? (event_idx == song0_last) : (event_idx == song1_last);

endmodule

//--- src/player_regs.sv
// player_regs: zero-wait APB slave with the control register and the beat status readback
`timescale 1ns/1ns
module player_regs (
   input  logic                     clk_4hz,
   input  logic                     reset,
   input  player_pkg::apb_req_t     apb,
   output player_pkg::apb_rsp_t     apb_resp,
   input  player_pkg::beat_t        beat,
   output player_pkg::player_ctrl_t ctrl
);

   logic access;
   logic ctrl_hit;
   logic status_hit;
   logic bad;
   logic wr_en;
   logic rd_en;

   assign access     = apb.psel & apb.penable;               // access phase
   assign ctrl_hit   = (apb.paddr == player_pkg::ctrl_addr);
   assign status_hit = (apb.paddr == player_pkg::status_addr);

   // unmapped offset, or a write to the read-only status
   assign bad = (!ctrl_hit && !status_hit) || (status_hit && apb.pwrite);

   assign wr_en = access & apb.pwrite & !bad;
   assign rd_en = access & !apb.pwrite & !bad;

   always_ff @(posedge clk_4hz)
   begin
      if (reset)
      begin
         ctrl <= '0;
      end
      else if (wr_en && ctrl_hit)
      begin
         ctrl <= player_pkg::player_ctrl_t'(apb.pwdata[2:0]);  // play, pause, song
      end
   end

   always_comb
   begin
      apb_resp.pready  = 1'b1;                               // never stalls
      apb_resp.pslverr = access & bad;
      apb_resp.prdata  = '0;
      if (rd_en)
      begin
         if (ctrl_hit)
         begin
            apb_resp.prdata = 32'(ctrl);
         end
         else
         begin
            apb_resp.prdata = 32'(beat);                     // song position
         end
      end
   end

endmodule

//--- src/player_pkg.sv
// player_pkg: shared widths, note codes, APB structs and note lookups for the melody player
package player_pkg;

   localparam int song_len = 150;                  // beats per song loop

   typedef logic [3:0]  digit_t;
   typedef logic [7:0]  beat_t;                    // 0 to 149
   typedef logic [4:0]  dur_t;                     // longest event is 17 beats
   typedef logic [6:0]  event_idx_t;
   typedef logic [13:0] tone_count_t;
   typedef logic        song_sel_t;

   localparam tone_count_t tone_max = 14'd16383;   // divider terminal count

   typedef enum logic [3:0] {
      rest, lo3, lo5, lo6, lo7, mid1, mid2, mid3, mid5, mid6, mid7, hi1
   } note_t;

   typedef struct packed {
      digit_t high;
      digit_t med;
      digit_t low;
   } note_digits_t;

   typedef struct packed {
      logic      play;                             // bit 2
      logic      pause;                            // bit 1
      song_sel_t song;                             // bit 0
   } player_ctrl_t;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [3:0]  paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   localparam logic [3:0] ctrl_addr   = 4'h0;
   localparam logic [3:0] status_addr = 4'h4;

   // divider start value, higher preset gives a higher pitch
   function automatic tone_count_t note_preset(note_t n);
      case (n)
         lo3:     return 14'd7281;
         lo5:     return 14'd8730;
         lo6:     return 14'd9565;
         lo7:     return 14'd10310;
         mid1:    return 14'd10647;
         mid2:    return 14'd11272;
         mid3:    return 14'd11831;
         mid5:    return 14'd12556;
         mid6:    return 14'd12974;
         mid7:    return 14'd13347;
         hi1:     return 14'd13516;
         default: return tone_max;                 // rest, divider parked
      endcase
   endfunction

   function automatic note_digits_t note_to_digits(note_t n);
      note_digits_t d;
      d = '0;
      case (n)
         lo3:     d.low  = 4'd3;
         lo5:     d.low  = 4'd5;
         lo6:     d.low  = 4'd6;
         lo7:     d.low  = 4'd7;
         mid1:    d.med  = 4'd1;
         mid2:    d.med  = 4'd2;
         mid3:    d.med  = 4'd3;
         mid5:    d.med  = 4'd5;
         mid6:    d.med  = 4'd6;
         mid7:    d.med  = 4'd7;
         hi1:     d.high = 4'd1;
         default: d = '0;                          // rest blanks all digits
      endcase
      return d;
   endfunction

endpackage
